/* Makefile */
TOP := tb_led_matrix

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) +verilator+error+limit+1000 > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "test failed" sim.log; then exit 1; fi
	@grep -q "test passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/led_matrix_assert.sv */
/* concurrent checks on the HUB75 pin timing
   bind into hub75_output */
`default_nettype none

module led_matrix_assert #(
    parameter int row_w = 4
) (
    input wire clk_root,
    input wire arst_n,
    input wire clk_pixel,
    input wire row_latch,
    input wire oe_n,
    input wire [row_w-1:0] row_addr
);
    timeunit 1ns;
    timeprecision 1ns;

    int fail_count = 0;  // picked up by the testbench

    // pins idle as reset lifts
    reset_idle: assert property (@(posedge clk_root)
        $rose(arst_n) |-> oe_n && !clk_pixel && !row_latch)
        else begin
            fail_count++;
            $error("pins not idle when reset was released");
        end

    latch_dark: assert property (@(posedge clk_root) disable iff (!arst_n)
        row_latch |-> oe_n && !clk_pixel)
        else begin
            fail_count++;
            $error("row_latch high while oe_n low or clk_pixel high");
        end

    shift_dark: assert property (@(posedge clk_root) disable iff (!arst_n)
        clk_pixel |-> oe_n)
        else begin
            fail_count++;
            $error("clk_pixel high while the panel is enabled");
        end

    // row select moves only with the output off
    row_steady: assert property (@(posedge clk_root) disable iff (!arst_n)
        !$stable(row_addr) |-> oe_n)
        else begin
            fail_count++;
            $error("row_addr changed while oe_n low");
        end

endmodule

bind hub75_output led_matrix_assert #(
    .row_w(row_w)
) u_led_matrix_assert (
    .clk_root(clk_root),
    .arst_n(arst_n),
    .clk_pixel(clk_pixel),
    .row_latch(row_latch),
    .oe_n(oe_n),
    .row_addr(row_addr)
);

`default_nettype wire

/* bench/led_matrix_cases.txt */
# colour_enable(hex) fill_kind(0 constant, 1 random, 2 aborted load then random)
# fill_value(hex: pixel byte for kind 0, aborted prefix length for kind 2) refreshes(dec)
7 0 3f 2
7 0 00 2
7 0 15 2
7 0 2a 2
7 1 00 3
1 1 00 2
2 1 00 2
4 1 00 2
3 0 3f 2
6 1 00 2
5 0 7f 2
0 1 00 2
7 2 17 3
7 2 05 2
7 1 00 3

/* bench/led_matrix_checker.sv */
/* scoreboard: framebuffer and colour enable model from the byte port,
   shifted row compare, scan order and display time checks */
`default_nettype none

module led_matrix_checker #(
    parameter int panel_columns = 8,
    parameter int scan_rows = 4,
    parameter int plane_base_ticks = 4
) (
    input wire clk_root,
    input wire arst_n,
    input wire [7:0] rx_byte,
    input wire rx_strobe,
    input wire [2:0] rgb_top,
    input wire [2:0] rgb_bottom,
    input wire [$clog2(scan_rows)-1:0] row_addr,
    input wire clk_pixel,
    input wire row_latch,
    input wire oe_n,
    output int errors,
    output int planes_checked,
    output int displays_checked
);
    timeunit 1ns;
    timeprecision 1ns;

    localparam int row_w = $clog2(scan_rows);
    localparam int pixels = 2 * scan_rows * panel_columns;
    localparam longint settle_cycles = 8;  // strobe to pins, with slack

    logic [5:0] fb_model [pixels];  // linear panel order, top rows first
    logic fb_valid [pixels];
    int load_idx;
    logic [2:0] en_model;
    longint cycle;
    longint last_strobe;
    longint first_sample;
    logic [2:0] top_q [$];
    logic [2:0] bottom_q [$];
    int exp_row;
    int exp_plane;
    int disp_plane;
    int low_cycles;
    logic [row_w-1:0] disp_row;
    logic clk_pixel_q;
    logic row_latch_q;
    logic oe_n_q;

    // red in bits 1:0, green 3:2, blue 5:4, plane picks the bit in each pair
    function automatic logic [2:0] expected_rgb(input logic [5:0] pix, input int p,
                                                input logic [2:0] en);
        return {pix[4 + p], pix[2 + p], pix[p]} & en;
    endfunction

    task automatic compare_plane();
        int top_i;
        int bot_i;
        logic [2:0] want_top;
        logic [2:0] want_bot;
        for (int k = 0; k < panel_columns; k++) begin
            top_i = int'(row_addr) * panel_columns + k;
            bot_i = top_i + scan_rows * panel_columns;  // same column, bottom half
            if (fb_valid[top_i] && fb_valid[bot_i]) begin
                want_top = expected_rgb(fb_model[top_i], exp_plane, en_model);
                want_bot = expected_rgb(fb_model[bot_i], exp_plane, en_model);
                if (top_q[k] !== want_top) begin
                    errors++;
                    $display("FAILED %0t ns rgb_top row %0d plane %0d col %0d: got %b expected %b",
                             $time, row_addr, exp_plane, k, top_q[k], want_top);
                end
                if (bottom_q[k] !== want_bot) begin
                    errors++;
                    $display("FAILED %0t ns rgb_bottom row %0d plane %0d col %0d: got %b expected %b",
                             $time, row_addr, exp_plane, k, bottom_q[k], want_bot);
                end
            end
        end
        planes_checked++;
    endtask

    always @(posedge clk_root) begin
        if (!arst_n) begin
            for (int i = 0; i < pixels; i++) begin
                fb_valid[i] = 1'b0;  // RAM holds garbage until loaded
            end
            load_idx = 0;
            en_model = 3'b111;
            cycle = 0;
            last_strobe = -100;
            first_sample = 0;
            top_q.delete();
            bottom_q.delete();
            exp_row = 0;
            exp_plane = 0;
            disp_plane = 0;
            disp_row = '0;
            low_cycles = 0;
            clk_pixel_q = 1'b0;
            row_latch_q = 1'b0;
            oe_n_q = 1'b1;
            errors = 0;
            planes_checked = 0;
            displays_checked = 0;
        end else begin
            cycle++;
            if (rx_strobe) begin
                last_strobe = cycle;
                if (!rx_byte[7]) begin
                    fb_model[load_idx] = rx_byte[5:0];
                    fb_valid[load_idx] = 1'b1;
                    load_idx = (load_idx == pixels - 1) ? 0 : load_idx + 1;
                end else if (!rx_byte[6]) begin
                    load_idx = 0;  // frame start
                end else begin
                    en_model = rx_byte[2:0];
                end
            end
            if (clk_pixel === 1'b1 && clk_pixel_q === 1'b0) begin
                if (top_q.size() == 0) first_sample = cycle;
                top_q.push_back(rgb_top);
                bottom_q.push_back(rgb_bottom);
            end
            if (row_latch === 1'b1 && row_latch_q === 1'b0) begin
                if (row_addr !== row_w'(exp_row)) begin
                    errors++;
                    $display("FAILED %0t ns row_addr at latch: got %0d expected %0d",
                             $time, row_addr, exp_row);
                end
                if (top_q.size() != panel_columns) begin
                    errors++;
                    $display("%0t ns: plane latched after %0d shift clocks instead of %0d",
                             $time, top_q.size(), panel_columns);
                end else if (last_strobe + settle_cycles < first_sample) begin
                    compare_plane();  // no byte touched this plane
                end
                disp_plane = exp_plane;
                disp_row = row_addr;
                if (exp_plane == led_panel_pkg::color_bits - 1) begin
                    exp_plane = 0;
                    exp_row = (exp_row == scan_rows - 1) ? 0 : exp_row + 1;
                end else begin
                    exp_plane++;
                end
                top_q.delete();
                bottom_q.delete();
            end
            if (oe_n === 1'b0) begin
                low_cycles++;
                if (row_addr !== disp_row) begin
                    errors++;
                    $display("FAILED %0t ns row_addr during display: got %0d expected %0d",
                             $time, row_addr, disp_row);
                end
            end else if (oe_n_q === 1'b0) begin
                if (low_cycles != (plane_base_ticks << disp_plane)) begin
                    errors++;
                    $display("FAILED %0t ns oe_n low cycles plane %0d: got %0d expected %0d",
                             $time, disp_plane, low_cycles, plane_base_ticks << disp_plane);
                end
                displays_checked++;
                low_cycles = 0;
            end
            clk_pixel_q = clk_pixel;
            row_latch_q = row_latch;
            oe_n_q = oe_n;
        end
    end

endmodule

`default_nettype wire

/* bench/tb_led_matrix.sv */
/* testbench for the LED matrix driver: clock, reset, case file reader,
   byte driver, watchdog and closing report */
`default_nettype none

module tb_led_matrix;
    timeunit 1ns;
    timeprecision 1ns;

    localparam int panel_columns = 8;
    localparam int scan_rows = 4;
    localparam int plane_base_ticks = 4;
    localparam int pixel_count = 2 * scan_rows * panel_columns;
    localparam int period_ns = 40;

    logic clk_root = 1'b0;
    logic arst_n;
    logic [7:0] rx_byte;
    logic rx_strobe;
    wire [2:0] rgb_top;
    wire [2:0] rgb_bottom;
    wire [$clog2(scan_rows)-1:0] row_addr;
    wire clk_pixel;
    wire row_latch;
    wire oe_n;

    int case_en [$];
    int case_kind [$];
    int case_value [$];
    int case_refresh [$];
    int bench_errors;
    int checker_errors;
    int assert_errors;
    int planes_checked;
    int displays_checked;
    longint watch_ns;
    bit limit_ready;

    always #(period_ns / 2) clk_root = ~clk_root;

    led_matrix_top #(
        .panel_columns(panel_columns),
        .scan_rows(scan_rows),
        .plane_base_ticks(plane_base_ticks)
    ) u_led_matrix_top (
        .clk_root(clk_root),
        .arst_n(arst_n),
        .rx_byte(rx_byte),
        .rx_strobe(rx_strobe),
        .rgb_top(rgb_top),
        .rgb_bottom(rgb_bottom),
        .row_addr(row_addr),
        .clk_pixel(clk_pixel),
        .row_latch(row_latch),
        .oe_n(oe_n)
    );

    led_matrix_checker #(
        .panel_columns(panel_columns),
        .scan_rows(scan_rows),
        .plane_base_ticks(plane_base_ticks)
    ) u_checker (
        .clk_root(clk_root),
        .arst_n(arst_n),
        .rx_byte(rx_byte),
        .rx_strobe(rx_strobe),
        .rgb_top(rgb_top),
        .rgb_bottom(rgb_bottom),
        .row_addr(row_addr),
        .clk_pixel(clk_pixel),
        .row_latch(row_latch),
        .oe_n(oe_n),
        .errors(checker_errors),
        .planes_checked(planes_checked),
        .displays_checked(displays_checked)
    );

    function automatic logic [7:0] random_pixel();
        return {1'b0, 7'($urandom)};  // bit 6 is don't care for pixels
    endfunction

    // one full pass over all rows and planes, in clk_root cycles
    function automatic int refresh_cycles();
        int total;
        total = 0;
        for (int p = 0; p < led_panel_pkg::color_bits; p++) begin
            total += 2 * panel_columns + 1 + (plane_base_ticks << p);
        end
        return total * scan_rows;
    endfunction

    task automatic send_byte(input logic [7:0] value);
        @(negedge clk_root);
        rx_byte = value;
        rx_strobe = 1'b1;
    endtask

    task automatic release_bus();
        @(negedge clk_root);
        rx_byte = 8'h00;
        rx_strobe = 1'b0;
    endtask

    task automatic wait_refreshes(input int count);
        repeat (count * scan_rows * led_panel_pkg::color_bits) @(posedge row_latch);
    endtask

    task automatic read_cases();
        int fd;
        int en;
        int kind;
        int value;
        int refresh;
        string line;
        fd = $fopen("bench/led_matrix_cases.txt", "r");
        if (fd == 0) begin
            bench_errors++;
            $display("could not open bench/led_matrix_cases.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#") begin
                    if ($sscanf(line, "%h %h %h %d", en, kind, value, refresh) == 4) begin
                        case_en.push_back(en);
                        case_kind.push_back(kind);
                        case_value.push_back(value);
                        case_refresh.push_back(refresh);
                    end else begin
                        bench_errors++;
                        $display("unreadable case line: %s", line);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_case(input int idx);
        logic [7:0] fill;
        send_byte({5'b11000, 3'(case_en[idx])});  // colour enable
        if (case_kind[idx] == 2) begin
            repeat (case_value[idx]) send_byte(random_pixel());  // cut short below
        end
        send_byte(8'h80);  // frame start
        for (int n = 0; n < pixel_count; n++) begin
            fill = (case_kind[idx] == 0) ? {1'b0, 7'(case_value[idx])} : random_pixel();
            send_byte(fill);
        end
        release_bus();
        wait_refreshes(case_refresh[idx]);
    endtask

    initial begin
        longint cycles;
        int total_errors;
        arst_n = 1'b0;
        rx_byte = 8'h00;
        rx_strobe = 1'b0;
        bench_errors = 0;
        limit_ready = 1'b0;
        void'($urandom(32'h9ac9_d465));
        read_cases();
        cycles = 0;
        foreach (case_refresh[i]) begin
            cycles += longint'(case_refresh[i] + 1) * refresh_cycles() + 3 * pixel_count;
        end
        watch_ns = (2 * cycles + 500) * period_ns;
        limit_ready = 1'b1;
        repeat (3) @(negedge clk_root);
        arst_n = 1'b1;
        foreach (case_en[i]) begin
            run_case(i);
        end
        assert_errors = u_led_matrix_top.u_hub75_output.u_led_matrix_assert.fail_count;
        total_errors = checker_errors + assert_errors + bench_errors;
        $display("errors %0d (checker %0d, assertions %0d, bench %0d), planes %0d, displays %0d",
                 total_errors, checker_errors, assert_errors, bench_errors,
                 planes_checked, displays_checked);
        if (total_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // watchdog, limit scales with the case list
    initial begin
        wait (limit_ready);
        #(watch_ns);
        $display("watchdog expired after %0d ns, the scan or a case stalled", watch_ns);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
source/led_panel_pkg.sv
source/command_decoder.sv
source/frame_buffer.sv
source/scan_sequencer.sv
source/subpanel_channel.sv
source/hub75_output.sv
source/led_matrix_top.sv
bench/led_matrix_assert.sv
bench/led_matrix_checker.sv
bench/tb_led_matrix.sv

/* source/command_decoder.sv */
/* byte decoder: pixel loads, frame start, colour enable
   drives the framebuffer write port one cycle after the strobe */
`default_nettype none

module command_decoder #(
    parameter int panel_columns = led_panel_pkg::default_panel_columns,
    parameter int scan_rows = led_panel_pkg::default_scan_rows
) (
    input wire clk_root,
    input wire arst_n,
    input wire [7:0] rx_byte,
    input wire rx_strobe,
    output logic wr_en,
    output logic [$clog2(scan_rows*panel_columns)-1:0] wr_addr,
    output logic wr_lane,
    output logic [led_panel_pkg::pixel_width-1:0] wr_pixel,
    output logic [2:0] rgb_enable
);

    localparam int words = scan_rows * panel_columns;  // per half
    localparam int pixels = 2 * words;
    localparam int idx_w = $clog2(pixels);
    localparam int addr_w = $clog2(words);

    logic [idx_w-1:0] pix_idx;  // linear index over both halves
    logic idx_lane;
    logic [addr_w-1:0] idx_addr;

    // bottom half rows start right after the last top half pixel
    assign idx_lane = (pix_idx >= idx_w'(words));
    assign idx_addr = idx_lane ? addr_w'(pix_idx - idx_w'(words)) : addr_w'(pix_idx);

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            wr_en <= 1'b0;
            pix_idx <= '0;
            rgb_enable <= 3'b111;
        end else begin
            wr_en <= 1'b0;
            if (rx_strobe) begin
                if (!rx_byte[7]) begin  // pixel byte
                    wr_en <= 1'b1;
                    pix_idx <= (pix_idx == idx_w'(pixels - 1)) ? '0 : pix_idx + 1'b1;
                end else if (!rx_byte[6]) begin
                    pix_idx <= '0;  // frame start
                end else begin
                    rgb_enable <= rx_byte[2:0];
                end
            end
        end
    end

    // write payload, only meaningful with wr_en
    always_ff @(posedge clk_root) begin
        if (rx_strobe) begin
            wr_addr <= idx_addr;
            wr_lane <= idx_lane;
            wr_pixel <= rx_byte[led_panel_pkg::pixel_width-1:0];
        end
    end

endmodule

`default_nettype wire

/* source/frame_buffer.sv */
/* dual-port framebuffer, one word per scan row and column
   half-word lane writes, registered read */
`default_nettype none

module frame_buffer #(
    parameter int panel_columns = led_panel_pkg::default_panel_columns,
    parameter int scan_rows = led_panel_pkg::default_scan_rows
) (
    input wire clk_root,
    input wire wr_en,
    input wire [$clog2(scan_rows*panel_columns)-1:0] wr_addr,
    input wire wr_lane,
    input wire [led_panel_pkg::pixel_width-1:0] wr_pixel,
    input wire [$clog2(scan_rows*panel_columns)-1:0] rd_addr,
    output led_panel_pkg::fb_word_u rd_word
);

    localparam int words = scan_rows * panel_columns;

    led_panel_pkg::fb_word_u mem [words];

    // write port, only the selected half changes
    always_ff @(posedge clk_root) begin
        if (wr_en) begin
            mem[wr_addr].half[wr_lane] <= wr_pixel;
        end
    end

    // read port, one cycle latency
    always_ff @(posedge clk_root) begin
        rd_word <= mem[rd_addr];
    end

endmodule

`default_nettype wire

/* source/hub75_output.sv */
/* HUB75 pin stage: two-cycle delay of the control strobes
   to meet the channel data, then registers for every pin */
`default_nettype none

module hub75_output #(
    parameter int row_w = 4
) (
    input wire clk_root,
    input wire arst_n,
    input wire [1:0][2:0] rgb_lanes,  // 0 top, 1 bottom
    input wire shift_clk,
    input wire latch,
    input wire display,
    input wire [row_w-1:0] row,
    output logic [2:0] rgb_top,
    output logic [2:0] rgb_bottom,
    output logic clk_pixel,
    output logic row_latch,
    output logic oe_n,
    output logic [row_w-1:0] row_addr
);

    localparam int ctrl_w = row_w + 3;

    logic [ctrl_w-1:0] ctrl_d1;
    logic [ctrl_w-1:0] ctrl_d2;  // {row, display, latch, shift_clk}

    // RAM read plus channel register
    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            ctrl_d1 <= '0;
            ctrl_d2 <= '0;
        end else begin
            ctrl_d1 <= {row, display, latch, shift_clk};
            ctrl_d2 <= ctrl_d1;
        end
    end

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            rgb_top <= '0;
            rgb_bottom <= '0;
            clk_pixel <= 1'b0;
            row_latch <= 1'b0;
            oe_n <= 1'b1;  // panel dark
            row_addr <= '0;
        end else begin
            rgb_top <= rgb_lanes[0];
            rgb_bottom <= rgb_lanes[1];
            clk_pixel <= ctrl_d2[0];
            row_latch <= ctrl_d2[1];
            oe_n <= ~ctrl_d2[2];
            row_addr <= ctrl_d2[ctrl_w-1:3];
        end
    end

endmodule

`default_nettype wire

/* source/led_matrix_top.sv */
/* LED matrix top level: byte decoder, framebuffer, scan sequencer,
   two subpanel channels and the HUB75 pin stage */
`default_nettype none

module led_matrix_top #(
    parameter int panel_columns = led_panel_pkg::default_panel_columns,
    parameter int scan_rows = led_panel_pkg::default_scan_rows,
    parameter int plane_base_ticks = led_panel_pkg::default_plane_base_ticks
) (
    input wire clk_root,
    input wire arst_n,
    input wire [7:0] rx_byte,
    input wire rx_strobe,
    output logic [2:0] rgb_top,
    output logic [2:0] rgb_bottom,
    output logic [$clog2(scan_rows)-1:0] row_addr,
    output logic clk_pixel,
    output logic row_latch,
    output logic oe_n
);

    localparam int addr_w = $clog2(scan_rows * panel_columns);
    localparam int row_w = $clog2(scan_rows);
    localparam int plane_w = $clog2(led_panel_pkg::color_bits);

    logic wr_en;
    logic [addr_w-1:0] wr_addr;
    logic wr_lane;
    logic [led_panel_pkg::pixel_width-1:0] wr_pixel;
    logic [2:0] rgb_enable;
    logic [addr_w-1:0] rd_addr;
    led_panel_pkg::fb_word_u rd_word;
    logic [plane_w-1:0] plane;
    logic shift_clk;
    logic latch;
    logic display;
    logic [row_w-1:0] row;
    wire [1:0][2:0] rgb_lanes;

    command_decoder #(
        .panel_columns(panel_columns),
        .scan_rows(scan_rows)
    ) u_command_decoder (
        .clk_root(clk_root),
        .arst_n(arst_n),
        .rx_byte(rx_byte),
        .rx_strobe(rx_strobe),
        .wr_en(wr_en),
        .wr_addr(wr_addr),
        .wr_lane(wr_lane),
        .wr_pixel(wr_pixel),
        .rgb_enable(rgb_enable)
    );

    frame_buffer #(
        .panel_columns(panel_columns),
        .scan_rows(scan_rows)
    ) u_frame_buffer (
        .clk_root(clk_root),
        .wr_en(wr_en),
        .wr_addr(wr_addr),
        .wr_lane(wr_lane),
        .wr_pixel(wr_pixel),
        .rd_addr(rd_addr),
        .rd_word(rd_word)
    );

    scan_sequencer #(
        .panel_columns(panel_columns),
        .scan_rows(scan_rows),
        .plane_base_ticks(plane_base_ticks)
    ) u_scan_sequencer (
        .clk_root(clk_root),
        .arst_n(arst_n),
        .rd_addr(rd_addr),
        .plane(plane),
        .shift_clk(shift_clk),
        .latch(latch),
        .display(display),
        .row(row)
    );

    // channel h takes half h of the word, 0 top and 1 bottom
    for (genvar h = 0; h < 2; h++) begin : g_channel
        subpanel_channel u_subpanel_channel (
            .clk_root(clk_root),
            .arst_n(arst_n),
            .pixel(rd_word.half[h]),
            .plane(plane),
            .rgb_enable(rgb_enable),
            .rgb(rgb_lanes[h])
        );
    end

    hub75_output #(
        .row_w(row_w)
    ) u_hub75_output (
        .clk_root(clk_root),
        .arst_n(arst_n),
        .rgb_lanes(rgb_lanes),
        .shift_clk(shift_clk),
        .latch(latch),
        .display(display),
        .row(row),
        .rgb_top(rgb_top),
        .rgb_bottom(rgb_bottom),
        .clk_pixel(clk_pixel),
        .row_latch(row_latch),
        .oe_n(oe_n),
        .row_addr(row_addr)
    );

endmodule

`default_nettype wire

/* source/led_panel_pkg.sv */
/* pixel and colour plane widths, default panel geometry,
   framebuffer word union shared by the RAM and the channels */
`default_nettype none

package led_panel_pkg;

    localparam int color_bits = 2;  // also the number of bit planes
    localparam int pixel_width = 3 * color_bits;  // blue 5:4, green 3:2, red 1:0

    localparam int default_panel_columns = 64;
    localparam int default_scan_rows = 16;
    localparam int default_plane_base_ticks = 32;

    // one RAM word holds the pixel of the top half and the one of the bottom half
    // that are shown on the same scan row and column
    typedef union packed {
        logic [2*pixel_width-1:0] raw;  // as stored in the RAM
        logic [1:0][pixel_width-1:0] half;  // 0 top, 1 bottom
    } fb_word_u;

endpackage

`default_nettype wire

/* source/scan_sequencer.sv */
/* scan sequencer: shift, latch and display phases per bit plane
   column, plane, row and display tick counters, framebuffer read address */
`default_nettype none

module scan_sequencer #(
    parameter int panel_columns = led_panel_pkg::default_panel_columns,
    parameter int scan_rows = led_panel_pkg::default_scan_rows,
    parameter int plane_base_ticks = led_panel_pkg::default_plane_base_ticks
) (
    input wire clk_root,
    input wire arst_n,
    output logic [$clog2(scan_rows*panel_columns)-1:0] rd_addr,
    output logic [$clog2(led_panel_pkg::color_bits)-1:0] plane,
    output logic shift_clk,
    output logic latch,
    output logic display,
    output logic [$clog2(scan_rows)-1:0] row
);

    localparam int addr_w = $clog2(scan_rows * panel_columns);
    localparam int col_w = $clog2(panel_columns);
    localparam int row_w = $clog2(scan_rows);
    localparam int plane_w = $clog2(led_panel_pkg::color_bits);
    localparam int max_ticks = plane_base_ticks << (led_panel_pkg::color_bits - 1);
    localparam int tick_w = $clog2(max_ticks + 1);

    localparam logic [1:0] ph_shift = 2'd0;
    localparam logic [1:0] ph_latch = 2'd1;
    localparam logic [1:0] ph_display = 2'd2;

    logic [1:0] phase;
    logic sclk_hi;  // second cycle of a column
    logic [col_w-1:0] col_q;
    logic [plane_w-1:0] plane_q;
    logic [row_w-1:0] row_q;
    logic [tick_w-1:0] ticks;
    logic [tick_w-1:0] display_len;

    // binary-coded modulation, plane p shows for base << p
    assign display_len = tick_w'(plane_base_ticks) << plane_q;

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            phase <= ph_shift;
            sclk_hi <= 1'b0;
            col_q <= '0;
            plane_q <= '0;
            row_q <= '0;
            ticks <= '0;
        end else begin
            case (phase)
                ph_shift: begin
                    sclk_hi <= ~sclk_hi;
                    if (sclk_hi) begin
                        if (col_q == col_w'(panel_columns - 1)) begin
                            col_q <= '0;
                            phase <= ph_latch;
                        end else begin
                            col_q <= col_q + 1'b1;
                        end
                    end
                end
                ph_latch: begin
                    ticks <= '0;
                    phase <= ph_display;
                end
                ph_display: begin
                    if (ticks == display_len - 1'b1) begin
                        ticks <= '0;
                        phase <= ph_shift;
                        // next plane, or first plane of the next row
                        if (plane_q == plane_w'(led_panel_pkg::color_bits - 1)) begin
                            plane_q <= '0;
                            if (row_q == row_w'(scan_rows - 1)) begin
                                row_q <= '0;
                            end else begin
                                row_q <= row_q + 1'b1;
                            end
                        end else begin
                            plane_q <= plane_q + 1'b1;
                        end
                    end else begin
                        ticks <= ticks + 1'b1;
                    end
                end
                default: phase <= ph_shift;
            endcase
        end
    end

    // address held for both cycles of a column
    assign rd_addr = addr_w'(row_q * panel_columns + col_q);
    assign plane = plane_q;
    assign row = row_q;

    assign shift_clk = (phase == ph_shift) && sclk_hi;  // low then high per column
    assign latch = (phase == ph_latch);
    assign display = (phase == ph_display);

endmodule

`default_nettype wire

/* source/subpanel_channel.sv */
/* one subpanel channel: picks the current plane bit of each colour,
   masks it with the colour enable and registers it */
`default_nettype none

module subpanel_channel (
    input wire clk_root,
    input wire arst_n,
    input wire [led_panel_pkg::pixel_width-1:0] pixel,
    input wire [$clog2(led_panel_pkg::color_bits)-1:0] plane,
    input wire [2:0] rgb_enable,
    output logic [2:0] rgb
);

    localparam int plane_w = $clog2(led_panel_pkg::color_bits);

    logic [plane_w-1:0] plane_d;  // lines up with the RAM read
    logic [2:0] plane_bits;

    // rgb[0] red, rgb[1] green, rgb[2] blue
    always_comb begin
        for (int c = 0; c < 3; c++) begin
            plane_bits[c] = pixel[c*led_panel_pkg::color_bits + int'(plane_d)];
        end
    end

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            plane_d <= '0;
            rgb <= '0;
        end else begin
            plane_d <= plane;
            rgb <= plane_bits & rgb_enable;
        end
    end

endmodule

`default_nettype wire
